//--- include/alu_params.svh
// Shared integer datapath widths and shared buffer count
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Data word width of the core
`define ALU_XLEN 32

// Adder width, one extra bit
// Top bit carries the less-than flag
`define ALU_ADDER_W (`ALU_XLEN + 1)

// Shift amount width, from op2[4:0]
`define ALU_SHAMT_W 5

// AGU shared buffers
`define ALU_SBF_NUM 2

`endif

//--- hw/alu_pkg.sv
// Datapath word types and operation flag struct for the shared integer datapath
`include "alu_params.svh"

package alu_pkg;

  // Plain data word
  typedef logic [`ALU_XLEN-1:0] xlen_t;

  // Adder word with sign extension bit
  typedef logic [`ALU_ADDER_W-1:0] adder_t;

  // Shift amount
  typedef logic [`ALU_SHAMT_W-1:0] shamt_t;

  // One flag per operation, at most one set per request
  typedef struct packed {
    logic op_add;
    logic op_sub;
    logic op_or;
    logic op_xor;
    logic op_and;
    logic op_sll;
    logic op_srl;
    logic op_sra;
    logic op_slt;
    logic op_sltu;
    logic op_mvop2;
    logic op_max;
    logic op_min;
    logic op_maxu;
    logic op_minu;
    // Branch compares
    logic op_cmp_eq;
    logic op_cmp_ne;
    logic op_cmp_lt;
    logic op_cmp_gt;
    logic op_cmp_ltu;
    logic op_cmp_gtu;
  } alu_ops_t;

endpackage

//--- hw/alu_dpath_if.sv
// Selected operands and operation flags from the request mux to the datapath units
`timescale 1ns/1ps
`include "alu_params.svh"

interface alu_dpath_if (
  input logic clk
);

  // Muxed operands
  alu_pkg::xlen_t op1;
  alu_pkg::xlen_t op2;

  // Muxed operation flags
  alu_pkg::alu_ops_t ops;

  // Request mux side
  modport src (
    output op1,
    output op2,
    output ops
  );

  // Unit side, clock for checks only
  modport dst (
    input clk,
    input op1,
    input op2,
    input ops
  );

endinterface

//--- hw/alu_req_mux.sv
// Request mux for ALU, BJP and AGU, plus the AGU shared buffers
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_req_mux (
  input  logic              clk,
  input  logic              rst_n,
  // ALU requestor
  input  logic              alu_req,
  input  alu_pkg::alu_ops_t alu_ops,
  input  alu_pkg::xlen_t    alu_op1,
  input  alu_pkg::xlen_t    alu_op2,
  // BJP requestor
  input  logic              bjp_req,
  input  alu_pkg::alu_ops_t bjp_ops,
  input  alu_pkg::xlen_t    bjp_op1,
  input  alu_pkg::xlen_t    bjp_op2,
  // AGU requestor
  input  logic              agu_req,
  input  alu_pkg::alu_ops_t agu_ops,
  input  alu_pkg::xlen_t    agu_op1,
  input  alu_pkg::xlen_t    agu_op2,
  // Shared buffers
  input  logic              sbf_0_ena,
  input  alu_pkg::xlen_t    sbf_0_nxt,
  output alu_pkg::xlen_t    sbf_0_r,
  input  logic              sbf_1_ena,
  input  alu_pkg::xlen_t    sbf_1_nxt,
  output alu_pkg::xlen_t    sbf_1_r,
  // To the units
  alu_dpath_if.src          dp
);

  localparam int OPS_W = $bits(alu_pkg::alu_ops_t);

  alu_pkg::alu_ops_t alu_ops_g;
  alu_pkg::alu_ops_t bjp_ops_g;
  alu_pkg::alu_ops_t agu_ops_g;

  logic [`ALU_SBF_NUM-1:0] sbf_ena;
  alu_pkg::xlen_t [`ALU_SBF_NUM-1:0] sbf_nxt;
  alu_pkg::xlen_t [`ALU_SBF_NUM-1:0] sbf_q;

  //////////////////////////////
  // AND-OR request mux

  // Flags masked by own request
  assign alu_ops_g = {OPS_W{alu_req}} & alu_ops;
  assign bjp_ops_g = {OPS_W{bjp_req}} & bjp_ops;
  assign agu_ops_g = {OPS_W{agu_req}} & agu_ops;

  // All zero when idle
  assign dp.ops = alu_ops_g | bjp_ops_g | agu_ops_g;

  // Operands masked the same way
  assign dp.op1 = ({`ALU_XLEN{alu_req}} & alu_op1)
                | ({`ALU_XLEN{bjp_req}} & bjp_op1)
                | ({`ALU_XLEN{agu_req}} & agu_op1);
  assign dp.op2 = ({`ALU_XLEN{alu_req}} & alu_op2)
                | ({`ALU_XLEN{bjp_req}} & bjp_op2)
                | ({`ALU_XLEN{agu_req}} & agu_op2);

  //////////////////////////////
  // AGU shared buffers

  // Gather into arrays
  assign sbf_ena = {sbf_1_ena, sbf_0_ena};
  assign sbf_nxt = {sbf_1_nxt, sbf_0_nxt};

  // Enable-loaded, hold otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sbf_q <= '0;
    end else begin
      for (int i = 0; i < `ALU_SBF_NUM; i++) begin
        if (sbf_ena[i]) begin
          sbf_q[i] <= sbf_nxt[i];
        end
      end
    end
  end

  assign sbf_0_r = sbf_q[0];
  assign sbf_1_r = sbf_q[1];

  //////////////////////////////
  // Checks

  // Requestors share the datapath by contract
  req_onehot_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({alu_req, bjp_req, agu_req})
  ) else $error("more than one requestor active");

  // Single operation reaches the units
  ops_onehot_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (alu_req | bjp_req | agu_req) |-> $onehot0(dp.ops)
  ) else $error("more than one operation flag active");

endmodule

//--- hw/alu_shifter.sv
// Single left shifter serving sll, srl and sra by bit reversal and sign masking
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_shifter (
  alu_dpath_if.dst       dp,
  output alu_pkg::xlen_t sll_res,
  output alu_pkg::xlen_t srl_res,
  output alu_pkg::xlen_t sra_res
);

  logic           op_shift;
  logic           op_right;
  alu_pkg::xlen_t sh_in;
  alu_pkg::shamt_t sh_amt;
  alu_pkg::xlen_t sh_res;
  alu_pkg::xlen_t eff_mask;

  // Mirror a word end for end
  function automatic alu_pkg::xlen_t bit_rev(input alu_pkg::xlen_t din);
    alu_pkg::xlen_t dout;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      dout[i] = din[`ALU_XLEN-1-i];
    end
    return dout;
  endfunction

  assign op_shift = dp.ops.op_sll | dp.ops.op_srl | dp.ops.op_sra;
  assign op_right = dp.ops.op_srl | dp.ops.op_sra;

  // Gated inputs, right shifts go in reversed
  assign sh_in  = {`ALU_XLEN{op_shift}} & (op_right ? bit_rev(dp.op1) : dp.op1);
  assign sh_amt = {`ALU_SHAMT_W{op_shift}} & dp.op2[`ALU_SHAMT_W-1:0];

  // The one shifter
  assign sh_res = sh_in << sh_amt;

  assign sll_res = sh_res;
  // Reverse back for logical right
  assign srl_res = bit_rev(sh_res);

  // Ones where srl kept bits
  assign eff_mask = {`ALU_XLEN{1'b1}} >> sh_amt;

  // Sign fill in vacated upper bits
  assign sra_res = (srl_res & eff_mask)
                 | ({`ALU_XLEN{dp.op1[`ALU_XLEN-1]}} & ~eff_mask);

endmodule

//--- hw/alu_adder_cmp.sv
// Shared gated adder/subtractor, gated XOR unit and branch compare result
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_adder_cmp (
  alu_dpath_if.dst        dp,
  output alu_pkg::adder_t adder_res,
  output alu_pkg::xlen_t  xor_res,
  output logic            cmp_res
);

  logic            op_unsigned;
  alu_pkg::adder_t adder_op1;
  alu_pkg::adder_t adder_op2;
  logic            adder_add;
  logic            adder_sub;
  logic            adder_addsub;
  alu_pkg::adder_t adder_in1;
  alu_pkg::adder_t adder_in2;
  logic            adder_cin;
  logic            xorer_op;
  alu_pkg::xlen_t  xorer_in1;
  alu_pkg::xlen_t  xorer_in2;
  logic            neq;
  logic            op1_ge_op2;

  //////////////////////////////
  // Adder

  // Zero extension for unsigned ops
  assign op_unsigned = dp.ops.op_sltu | dp.ops.op_cmp_ltu | dp.ops.op_cmp_gtu
                     | dp.ops.op_maxu | dp.ops.op_minu;

  assign adder_op1 = {{(`ALU_ADDER_W - `ALU_XLEN){~op_unsigned & dp.op1[`ALU_XLEN-1]}},
                      dp.op1};
  assign adder_op2 = {{(`ALU_ADDER_W - `ALU_XLEN){~op_unsigned & dp.op2[`ALU_XLEN-1]}},
                      dp.op2};

  assign adder_add = dp.ops.op_add;
  // Every compare is a subtract
  assign adder_sub = dp.ops.op_sub
                   | dp.ops.op_cmp_lt | dp.ops.op_cmp_gt
                   | dp.ops.op_cmp_ltu | dp.ops.op_cmp_gtu
                   | dp.ops.op_max | dp.ops.op_maxu
                   | dp.ops.op_min | dp.ops.op_minu
                   | dp.ops.op_slt | dp.ops.op_sltu;
  assign adder_addsub = adder_add | adder_sub;

  // Gated inputs, invert plus carry for sub
  assign adder_in1 = {`ALU_ADDER_W{adder_addsub}} & adder_op1;
  assign adder_in2 = {`ALU_ADDER_W{adder_addsub}} & (adder_sub ? ~adder_op2 : adder_op2);
  assign adder_cin = adder_addsub & adder_sub;

  assign adder_res = adder_in1 + adder_in2 + alu_pkg::adder_t'(adder_cin);

  //////////////////////////////
  // XOR unit

  // Also serves eq and ne
  assign xorer_op  = dp.ops.op_xor | dp.ops.op_cmp_eq | dp.ops.op_cmp_ne;
  assign xorer_in1 = {`ALU_XLEN{xorer_op}} & dp.op1;
  assign xorer_in2 = {`ALU_XLEN{xorer_op}} & dp.op2;
  assign xor_res   = xorer_in1 ^ xorer_in2;

  //////////////////////////////
  // Branch compare

  // Any differing bit
  assign neq = |xor_res;
  // Top adder bit clear means op1 >= op2
  assign op1_ge_op2 = ~adder_res[`ALU_XLEN];

  assign cmp_res = (dp.ops.op_cmp_eq  & ~neq)
                 | (dp.ops.op_cmp_ne  & neq)
                 | (dp.ops.op_cmp_lt  & adder_res[`ALU_XLEN])
                 | (dp.ops.op_cmp_ltu & adder_res[`ALU_XLEN])
                 | (dp.ops.op_cmp_gt  & op1_ge_op2)
                 | (dp.ops.op_cmp_gtu & op1_ge_op2);

  // Adder quiet unless an add or subtract is requested
  adder_idle_a: assert property (
    @(posedge dp.clk)
    !adder_addsub |-> (adder_res == '0)
  ) else $error("adder active without an adder operation");

endmodule

//--- hw/alu_result_sel.sv
// Light logic results and the AND-OR final result mux of the datapath
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_result_sel (
  alu_dpath_if.dst        dp,
  input  alu_pkg::xlen_t  sll_res,
  input  alu_pkg::xlen_t  srl_res,
  input  alu_pkg::xlen_t  sra_res,
  input  alu_pkg::adder_t adder_res,
  input  alu_pkg::xlen_t  xor_res,
  output alu_pkg::xlen_t  res
);

  alu_pkg::xlen_t or_res;
  alu_pkg::xlen_t and_res;
  alu_pkg::xlen_t mvop2_res;
  logic           op_addsub;
  logic           op_slttu;
  logic           op_maxmin;
  logic           slttu_lt;
  alu_pkg::xlen_t slttu_res;
  logic           op1_ge_op2;
  logic           maxmin_sel_op1;
  alu_pkg::xlen_t maxmin_res;

  //////////////////////////////
  // Candidate results

  // Cheap ops, no gating
  assign or_res  = dp.op1 | dp.op2;
  assign and_res = dp.op1 & dp.op2;

  // lui and swap just pass op2
  assign mvop2_res = dp.op2;

  // Only a real add or sub takes the sum
  assign op_addsub = dp.ops.op_add | dp.ops.op_sub;

  // slt and sltu reuse the adder sign
  assign op_slttu  = dp.ops.op_slt | dp.ops.op_sltu;
  assign slttu_lt  = op_slttu & adder_res[`ALU_XLEN];
  assign slttu_res = {{(`ALU_XLEN - 1){1'b0}}, slttu_lt};

  // Max and min from the same subtract
  assign op_maxmin  = dp.ops.op_max | dp.ops.op_maxu | dp.ops.op_min | dp.ops.op_minu;
  assign op1_ge_op2 = ~adder_res[`ALU_XLEN];
  assign maxmin_sel_op1 = ((dp.ops.op_max | dp.ops.op_maxu) & op1_ge_op2)
                        | ((dp.ops.op_min | dp.ops.op_minu) & ~op1_ge_op2);
  assign maxmin_res = maxmin_sel_op1 ? dp.op1 : dp.op2;

  //////////////////////////////
  // Final AND-OR mux

  // Zero when no flag set
  assign res = ({`ALU_XLEN{dp.ops.op_or}}    & or_res)
             | ({`ALU_XLEN{dp.ops.op_and}}   & and_res)
             | ({`ALU_XLEN{dp.ops.op_xor}}   & xor_res)
             | ({`ALU_XLEN{op_addsub}}       & adder_res[`ALU_XLEN-1:0])
             | ({`ALU_XLEN{dp.ops.op_sll}}   & sll_res)
             | ({`ALU_XLEN{dp.ops.op_srl}}   & srl_res)
             | ({`ALU_XLEN{dp.ops.op_sra}}   & sra_res)
             | ({`ALU_XLEN{dp.ops.op_mvop2}} & mvop2_res)
             | ({`ALU_XLEN{op_slttu}}        & slttu_res)
             | ({`ALU_XLEN{op_maxmin}}       & maxmin_res);

endmodule

//--- hw/alu_dpath_top.sv
// Shared integer datapath top level with plain ALU, BJP and AGU requestor ports
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_dpath_top (
  input  logic           clk,
  input  logic           rst_n,
  // ALU requestor
  input  logic           alu_req,
  input  logic           alu_add,
  input  logic           alu_sub,
  input  logic           alu_xor,
  input  logic           alu_sll,
  input  logic           alu_srl,
  input  logic           alu_sra,
  input  logic           alu_or,
  input  logic           alu_and,
  input  logic           alu_slt,
  input  logic           alu_sltu,
  input  logic           alu_lui,
  input  alu_pkg::xlen_t alu_op1,
  input  alu_pkg::xlen_t alu_op2,
  output alu_pkg::xlen_t alu_res,
  // BJP requestor
  input  logic           bjp_req,
  input  alu_pkg::xlen_t bjp_op1,
  input  alu_pkg::xlen_t bjp_op2,
  input  logic           bjp_cmp_eq,
  input  logic           bjp_cmp_ne,
  input  logic           bjp_cmp_lt,
  input  logic           bjp_cmp_gt,
  input  logic           bjp_cmp_ltu,
  input  logic           bjp_cmp_gtu,
  input  logic           bjp_add,
  output logic           bjp_cmp_res,
  output alu_pkg::xlen_t bjp_add_res,
  // AGU requestor
  input  logic           agu_req,
  input  alu_pkg::xlen_t agu_op1,
  input  alu_pkg::xlen_t agu_op2,
  input  logic           agu_swap,
  input  logic           agu_add,
  input  logic           agu_and,
  input  logic           agu_or,
  input  logic           agu_xor,
  input  logic           agu_max,
  input  logic           agu_min,
  input  logic           agu_maxu,
  input  logic           agu_minu,
  output alu_pkg::xlen_t agu_res,
  // AGU shared buffers
  input  logic           agu_sbf_0_ena,
  input  alu_pkg::xlen_t agu_sbf_0_nxt,
  output alu_pkg::xlen_t agu_sbf_0_r,
  input  logic           agu_sbf_1_ena,
  input  alu_pkg::xlen_t agu_sbf_1_nxt,
  output alu_pkg::xlen_t agu_sbf_1_r
);

  alu_pkg::alu_ops_t alu_ops;
  alu_pkg::alu_ops_t bjp_ops;
  alu_pkg::alu_ops_t agu_ops;
  alu_pkg::xlen_t    sll_res;
  alu_pkg::xlen_t    srl_res;
  alu_pkg::xlen_t    sra_res;
  alu_pkg::adder_t   adder_res;
  alu_pkg::xlen_t    xor_res;
  alu_pkg::xlen_t    dpath_res;

  //////////////////////////////
  // Flag packing per requestor

  // lui is a move of op2
  assign alu_ops = '{op_add: alu_add, op_sub: alu_sub, op_xor: alu_xor,
                     op_sll: alu_sll, op_srl: alu_srl, op_sra: alu_sra,
                     op_or: alu_or, op_and: alu_and, op_slt: alu_slt,
                     op_sltu: alu_sltu, op_mvop2: alu_lui, default: 1'b0};

  assign bjp_ops = '{op_cmp_eq: bjp_cmp_eq, op_cmp_ne: bjp_cmp_ne,
                     op_cmp_lt: bjp_cmp_lt, op_cmp_gt: bjp_cmp_gt,
                     op_cmp_ltu: bjp_cmp_ltu, op_cmp_gtu: bjp_cmp_gtu,
                     op_add: bjp_add, default: 1'b0};

  // swap is also a move of op2
  assign agu_ops = '{op_mvop2: agu_swap, op_add: agu_add, op_and: agu_and,
                     op_or: agu_or, op_xor: agu_xor, op_max: agu_max,
                     op_min: agu_min, op_maxu: agu_maxu, op_minu: agu_minu,
                     default: 1'b0};

  //////////////////////////////
  // Datapath

  alu_dpath_if dpath_if (.clk(clk));

  alu_req_mux u_req_mux (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_req   (alu_req),
    .alu_ops   (alu_ops),
    .alu_op1   (alu_op1),
    .alu_op2   (alu_op2),
    .bjp_req   (bjp_req),
    .bjp_ops   (bjp_ops),
    .bjp_op1   (bjp_op1),
    .bjp_op2   (bjp_op2),
    .agu_req   (agu_req),
    .agu_ops   (agu_ops),
    .agu_op1   (agu_op1),
    .agu_op2   (agu_op2),
    .sbf_0_ena (agu_sbf_0_ena),
    .sbf_0_nxt (agu_sbf_0_nxt),
    .sbf_0_r   (agu_sbf_0_r),
    .sbf_1_ena (agu_sbf_1_ena),
    .sbf_1_nxt (agu_sbf_1_nxt),
    .sbf_1_r   (agu_sbf_1_r),
    .dp        (dpath_if.src)
  );

  alu_shifter u_shifter (
    .dp      (dpath_if.dst),
    .sll_res (sll_res),
    .srl_res (srl_res),
    .sra_res (sra_res)
  );

  alu_adder_cmp u_adder_cmp (
    .dp        (dpath_if.dst),
    .adder_res (adder_res),
    .xor_res   (xor_res),
    .cmp_res   (bjp_cmp_res)
  );

  alu_result_sel u_result_sel (
    .dp        (dpath_if.dst),
    .sll_res   (sll_res),
    .srl_res   (srl_res),
    .sra_res   (sra_res),
    .adder_res (adder_res),
    .xor_res   (xor_res),
    .res       (dpath_res)
  );

  // One result word for every requestor
  assign alu_res     = dpath_res;
  assign agu_res     = dpath_res;
  assign bjp_add_res = dpath_res;

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock and reset source, 100 ns clock with reset held for two cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 50;

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Low for the first two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- verification/alu_dpath_tb.sv
// Testbench for the shared integer datapath with reference model and self checks
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_dpath_tb;

  //////////////////////////////
  // Operation codes, one per request flag

  localparam int OP_IDLE     = 0;
  localparam int OP_ALU_ADD  = 1;
  localparam int OP_ALU_SUB  = 2;
  localparam int OP_ALU_XOR  = 3;
  localparam int OP_ALU_OR   = 4;
  localparam int OP_ALU_AND  = 5;
  localparam int OP_ALU_SLT  = 6;
  localparam int OP_ALU_SLTU = 7;
  localparam int OP_ALU_LUI  = 8;
  localparam int OP_ALU_SLL  = 9;
  localparam int OP_ALU_SRL  = 10;
  localparam int OP_ALU_SRA  = 11;
  localparam int OP_BJP_EQ   = 12;
  localparam int OP_BJP_NE   = 13;
  localparam int OP_BJP_LT   = 14;
  localparam int OP_BJP_GT   = 15;
  localparam int OP_BJP_LTU  = 16;
  localparam int OP_BJP_GTU  = 17;
  localparam int OP_BJP_ADD  = 18;
  localparam int OP_AGU_ADD  = 19;
  localparam int OP_AGU_AND  = 20;
  localparam int OP_AGU_OR   = 21;
  localparam int OP_AGU_XOR  = 22;
  localparam int OP_AGU_MAX  = 23;
  localparam int OP_AGU_MIN  = 24;
  localparam int OP_AGU_MAXU = 25;
  localparam int OP_AGU_MINU = 26;
  localparam int OP_AGU_SWAP = 27;
  localparam int NUM_OPS     = 28;

  // Five corner pairs then random pairs, one idle after each op
  localparam int N_PER_OP    = 16;
  localparam int N_IDLE_TAIL = 8;
  localparam int N_VEC       = (NUM_OPS - 1) * (N_PER_OP + 1) + N_IDLE_TAIL;
  localparam int CLK_PERIOD  = 100;

  logic clk;
  logic rst_n;
  logic [NUM_OPS-1:0] sel;
  alu_pkg::xlen_t alu_op1, alu_op2, bjp_op1, bjp_op2, agu_op1, agu_op2;
  logic agu_sbf_0_ena, agu_sbf_1_ena;
  alu_pkg::xlen_t agu_sbf_0_nxt, agu_sbf_1_nxt;
  alu_pkg::xlen_t alu_res, agu_res, bjp_add_res, agu_sbf_0_r, agu_sbf_1_r;
  logic bjp_cmp_res;

  // Request currently on the DUT inputs
  int cur_op;
  alu_pkg::xlen_t cur_a, cur_b;
  alu_pkg::xlen_t stim_a, stim_b;
  alu_pkg::xlen_t exp_res, sbf_exp_0, sbf_exp_1;
  logic exp_cmp;
  integer seed;
  int word_errs;
  int bit_errs;

  tb_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

  alu_dpath_top uut (
    .clk(clk), .rst_n(rst_n),
    .alu_req(|sel[OP_ALU_SRA:OP_ALU_ADD]),
    .alu_add(sel[OP_ALU_ADD]), .alu_sub(sel[OP_ALU_SUB]), .alu_xor(sel[OP_ALU_XOR]),
    .alu_sll(sel[OP_ALU_SLL]), .alu_srl(sel[OP_ALU_SRL]), .alu_sra(sel[OP_ALU_SRA]),
    .alu_or(sel[OP_ALU_OR]), .alu_and(sel[OP_ALU_AND]), .alu_slt(sel[OP_ALU_SLT]),
    .alu_sltu(sel[OP_ALU_SLTU]), .alu_lui(sel[OP_ALU_LUI]),
    .alu_op1(alu_op1), .alu_op2(alu_op2), .alu_res(alu_res),
    .bjp_req(|sel[OP_BJP_ADD:OP_BJP_EQ]), .bjp_op1(bjp_op1), .bjp_op2(bjp_op2),
    .bjp_cmp_eq(sel[OP_BJP_EQ]), .bjp_cmp_ne(sel[OP_BJP_NE]), .bjp_cmp_lt(sel[OP_BJP_LT]),
    .bjp_cmp_gt(sel[OP_BJP_GT]), .bjp_cmp_ltu(sel[OP_BJP_LTU]),
    .bjp_cmp_gtu(sel[OP_BJP_GTU]), .bjp_add(sel[OP_BJP_ADD]),
    .bjp_cmp_res(bjp_cmp_res), .bjp_add_res(bjp_add_res),
    .agu_req(|sel[OP_AGU_SWAP:OP_AGU_ADD]), .agu_op1(agu_op1), .agu_op2(agu_op2),
    .agu_swap(sel[OP_AGU_SWAP]), .agu_add(sel[OP_AGU_ADD]), .agu_and(sel[OP_AGU_AND]),
    .agu_or(sel[OP_AGU_OR]), .agu_xor(sel[OP_AGU_XOR]), .agu_max(sel[OP_AGU_MAX]),
    .agu_min(sel[OP_AGU_MIN]), .agu_maxu(sel[OP_AGU_MAXU]), .agu_minu(sel[OP_AGU_MINU]),
    .agu_res(agu_res),
    .agu_sbf_0_ena(agu_sbf_0_ena), .agu_sbf_0_nxt(agu_sbf_0_nxt), .agu_sbf_0_r(agu_sbf_0_r),
    .agu_sbf_1_ena(agu_sbf_1_ena), .agu_sbf_1_nxt(agu_sbf_1_nxt), .agu_sbf_1_r(agu_sbf_1_r)
  );

  //////////////////////////////
  // Reference model

  // 1 ALU, 2 BJP, 3 AGU, 0 idle
  function automatic int req_group(input int op);
    if (op >= OP_AGU_ADD) return 3;
    if (op >= OP_BJP_EQ) return 2;
    if (op >= OP_ALU_ADD) return 1;
    return 0;
  endfunction

  // Expected result word, compare bit through cmp
  function automatic alu_pkg::xlen_t alu_ref(input int op, input alu_pkg::xlen_t a,
                                             input alu_pkg::xlen_t b, output logic cmp);
    logic signed [`ALU_XLEN-1:0] sa;
    logic signed [`ALU_XLEN-1:0] sb;
    alu_pkg::xlen_t res;
    sa  = a;
    sb  = b;
    res = '0;
    cmp = 1'b0;
    case (op)
      OP_ALU_ADD, OP_BJP_ADD, OP_AGU_ADD: res = a + b;
      OP_ALU_SUB:              res = a - b;
      OP_ALU_XOR, OP_AGU_XOR:  res = a ^ b;
      OP_ALU_OR, OP_AGU_OR:    res = a | b;
      OP_ALU_AND, OP_AGU_AND:  res = a & b;
      OP_ALU_SLT:              res = alu_pkg::xlen_t'(sa < sb);
      OP_ALU_SLTU:             res = alu_pkg::xlen_t'(a < b);
      OP_ALU_LUI, OP_AGU_SWAP: res = b;
      OP_ALU_SLL:              res = a << b[4:0];
      OP_ALU_SRL:              res = a >> b[4:0];
      OP_ALU_SRA:              res = sa >>> b[4:0];
      OP_BJP_EQ:               cmp = (a == b);
      OP_BJP_NE:               cmp = (a != b);
      OP_BJP_LT:               cmp = (sa < sb);
      // gt really means greater or equal
      OP_BJP_GT:               cmp = (sa >= sb);
      OP_BJP_LTU:              cmp = (a < b);
      OP_BJP_GTU:              cmp = (a >= b);
      OP_AGU_MAX:              res = (sa >= sb) ? a : b;
      OP_AGU_MIN:              res = (sa < sb) ? a : b;
      OP_AGU_MAXU:             res = (a >= b) ? a : b;
      OP_AGU_MINU:             res = (a < b) ? a : b;
      default:                 res = '0;
    endcase
    return res;
  endfunction

  //////////////////////////////
  // Compare tasks

  task automatic check_word(input string name, input alu_pkg::xlen_t got,
                            input alu_pkg::xlen_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("FAILED %s: got %h expected %h (op %0d, a %h, b %h) at %0t",
               name, got, exp, cur_op, cur_a, cur_b, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("FAILED %s: got %h expected %h (op %0d, a %h, b %h) at %0t",
               name, got, exp, cur_op, cur_a, cur_b, $time);
    end
  endtask

  // Buffer model, enable-loaded
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sbf_exp_0 <= '0;
      sbf_exp_1 <= '0;
    end else begin
      if (agu_sbf_0_ena) sbf_exp_0 <= agu_sbf_0_nxt;
      if (agu_sbf_1_ena) sbf_exp_1 <= agu_sbf_1_nxt;
    end
  end

  // Outputs settled mid cycle
  always @(negedge clk) begin
    if (rst_n) begin
      exp_res = alu_ref(cur_op, cur_a, cur_b, exp_cmp);
      check_word("alu_res", alu_res, exp_res);
      check_word("agu_res", agu_res, exp_res);
      check_word("bjp_add_res", bjp_add_res, exp_res);
      check_bit("bjp_cmp_res", bjp_cmp_res, exp_cmp);
      check_word("agu_sbf_0_r", agu_sbf_0_r, sbf_exp_0);
      check_word("agu_sbf_1_r", agu_sbf_1_r, sbf_exp_1);
    end
  end

  //////////////////////////////
  // Stimulus

  // Idle requestors carry junk operands to exercise the gating
  task automatic apply_vec(input int op, input alu_pkg::xlen_t a, input alu_pkg::xlen_t b);
    logic [NUM_OPS-1:0] one_hot;
    logic [31:0] rnd;
    int grp;
    one_hot = '0;
    if (op != OP_IDLE) one_hot[op] = 1'b1;
    grp = req_group(op);
    @(posedge clk);
    sel     <= one_hot;
    cur_op  <= op;
    cur_a   <= a;
    cur_b   <= b;
    alu_op1 <= (grp == 1) ? a : alu_pkg::xlen_t'($random(seed));
    alu_op2 <= (grp == 1) ? b : alu_pkg::xlen_t'($random(seed));
    bjp_op1 <= (grp == 2) ? a : alu_pkg::xlen_t'($random(seed));
    bjp_op2 <= (grp == 2) ? b : alu_pkg::xlen_t'($random(seed));
    agu_op1 <= (grp == 3) ? a : alu_pkg::xlen_t'($random(seed));
    agu_op2 <= (grp == 3) ? b : alu_pkg::xlen_t'($random(seed));
    // Buffers loaded on about half the cycles
    rnd = $random(seed);
    agu_sbf_0_ena <= rnd[0];
    agu_sbf_1_ena <= rnd[1];
    agu_sbf_0_nxt <= $random(seed);
    agu_sbf_1_nxt <= $random(seed);
  endtask

  initial begin
    seed = 32'h7665_4718;
    word_errs = 0;
    bit_errs = 0;
    sel = '0;
    cur_op = OP_IDLE;
    cur_a = '0;
    cur_b = '0;
    {alu_op1, alu_op2, bjp_op1, bjp_op2, agu_op1, agu_op2} = '0;
    {agu_sbf_0_ena, agu_sbf_1_ena} = 2'b00;
    {agu_sbf_0_nxt, agu_sbf_1_nxt} = '0;
    wait (rst_n === 1'b1);
    for (int op = OP_ALU_ADD; op < NUM_OPS; op++) begin
      for (int k = 0; k < N_PER_OP; k++) begin
        stim_a = $random(seed);
        stim_b = $random(seed);
        case (k)
          0: stim_b = stim_a;
          // Sign-differing pairs
          1: begin
            stim_a[`ALU_XLEN-1] = 1'b1;
            stim_b[`ALU_XLEN-1] = 1'b0;
          end
          2: begin
            stim_a[`ALU_XLEN-1] = 1'b0;
            stim_b[`ALU_XLEN-1] = 1'b1;
          end
          // Shift amount extremes
          3: stim_b[`ALU_SHAMT_W-1:0] = '0;
          4: stim_b[`ALU_SHAMT_W-1:0] = '1;
          default: ;
        endcase
        apply_vec(op, stim_a, stim_b);
      end
      apply_vec(OP_IDLE, $random(seed), $random(seed));
    end
    repeat (N_IDLE_TAIL) apply_vec(OP_IDLE, $random(seed), $random(seed));
    repeat (2) @(posedge clk);
    $display("Summary: %0d vectors, %0d word mismatches, %0d bit mismatches",
             N_VEC, word_errs, bit_errs);
    if (word_errs + bit_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog, all vectors plus margin
  initial begin
    #((N_VEC + 20) * CLK_PERIOD);
    $display("Error: the run timed out before all vectors were applied");
    $display("Regression failed");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
hw/alu_pkg.sv
hw/alu_dpath_if.sv
hw/alu_req_mux.sv
hw/alu_shifter.sv
hw/alu_adder_cmp.sv
hw/alu_result_sel.sv
hw/alu_dpath_top.sv
verification/tb_clk_gen.sv
verification/alu_dpath_tb.sv
